/* hw/fme_csr_pkg.sv */
// Register map of the management block. Word addressed, 64-bit registers
// Status bits 0..3 come from fabric levels, bits 4..6 from software injection

package fme_csr_pkg;

   //----------------------------------------------------------------------
   // Register bus geometry
   //----------------------------------------------------------------------
   localparam int REG_ADDR_W = 4;          // Word address, 16 slots
   localparam int REG_DATA_W = 64;

   // Word addresses, everything above ADDR_ERR_FIRST is unmapped
   localparam logic [REG_ADDR_W-1:0] ADDR_DFH        = 4'd0;
   localparam logic [REG_ADDR_W-1:0] ADDR_SCRATCH    = 4'd1;
   localparam logic [REG_ADDR_W-1:0] ADDR_ERR_STATUS = 4'd2;  // Sticky, W1C
   localparam logic [REG_ADDR_W-1:0] ADDR_ERR_MASK   = 4'd3;
   localparam logic [REG_ADDR_W-1:0] ADDR_ERR_INJECT = 4'd4;
   localparam logic [REG_ADDR_W-1:0] ADDR_ERR_FIRST  = 4'd5;  // Write clears

   //----------------------------------------------------------------------
   // Error vector layout
   //----------------------------------------------------------------------
   // Bit 0 parity, bit 1 fabric, bits 2..3 generic
   localparam int N_ERR_SRC = 4;

   // Injected errors, same order as ERR_INJECT bits 0..2
   localparam int ERR_BIT_CAT_INJ  = 4;    // Catastrophic
   localparam int ERR_BIT_FAT_INJ  = 5;    // Fatal
   localparam int ERR_BIT_WARN_INJ = 6;    // Warning

   localparam int N_ERR     = 7;           // Upper status bits read 0
   localparam int N_ERR_INJ = N_ERR - N_ERR_SRC;

   typedef logic [N_ERR-1:0] err_vec_t;

   //----------------------------------------------------------------------
   // Device feature header fields
   //----------------------------------------------------------------------
   localparam int DFH_ID_W     = 12;       // Bits 11:0
   localparam int DFH_NEXT_W   = 24;       // Bits 39:16
   localparam int DFH_NEXT_LSB = 16;
   localparam int DFH_EOL_BIT  = 40;       // End of feature list

   localparam logic [DFH_ID_W-1:0] DFH_FEATURE_ID = 12'h0FE;

   // Reset values
   localparam err_vec_t ERR_MASK_RESET = '0;  // All sources enabled

endpackage

/* hw/fme_msg_pkg.sv */
// Command and message types shared by the register path and the IRQ sender
// Message is a single address plus data write, no byte enables

package fme_msg_pkg;

   //----------------------------------------------------------------------
   // Decoded register command
   //----------------------------------------------------------------------
   typedef enum logic [1:0] {
      CMD_IDLE  = 2'd0,    // No request this cycle
      CMD_READ  = 2'd1,
      CMD_WRITE = 2'd2
   } reg_cmd_t;

   //----------------------------------------------------------------------
   // Interrupt sender FSM
   //----------------------------------------------------------------------
   typedef enum logic {
      MSG_IDLE = 1'b0,
      MSG_SEND = 1'b1      // msg_valid held until msg_ready
   } msg_state_t;

   // Outbound message fields
   localparam int MSG_ADDR_W = 20;
   localparam int MSG_DATA_W = 64;

endpackage

/* hw/fme_regbus_if.sv */
// Decoded register request, one cycle per command
// rdata is combinational from addr, the requester samples it

`timescale 1ns/10ps

interface fme_regbus_if
   import fme_csr_pkg::*;
   import fme_msg_pkg::*;
();

   reg_cmd_t              cmd;      // CMD_IDLE between requests
   logic [REG_ADDR_W-1:0] addr;     // Word address
   logic [REG_DATA_W-1:0] wdata;    // Valid with CMD_WRITE
   logic [REG_DATA_W-1:0] rdata;    // Same-cycle read data

   // Request side
   modport master (
      output cmd,
      output addr,
      output wdata,
      input  rdata
   );

   // Register block side
   modport slave (
      input  cmd,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

/* hw/fme_mmio_front.sv */
// Host side of the register path. No backpressure, a request may come every cycle
// Read response arrives two edges after the request is sampled

`timescale 1ns/10ps

module fme_mmio_front
   import fme_csr_pkg::*;
   import fme_msg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  host_valid,
   input  logic                  host_write,
   input  logic [REG_ADDR_W-1:0] host_addr,
   input  logic [REG_DATA_W-1:0] host_wdata,
   output logic                  host_rvalid,
   output logic [REG_DATA_W-1:0] host_rdata,
   fme_regbus_if.master          bus
);

   logic rd_pend;    // Read command on the bus this cycle

   //----------------------------------------------------------------------
   // Request stage, edge N
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.cmd <= CMD_IDLE;
         rd_pend <= 1'b0;
      end else begin
         bus.cmd <= CMD_IDLE;                  // One-cycle command
         if (host_valid) begin
            bus.cmd <= host_write ? CMD_WRITE : CMD_READ;
         end
         rd_pend <= host_valid & ~host_write;
      end
   end

   // Address and data ride along with the command
   always_ff @(posedge clk) begin
      if (host_valid) begin
         bus.addr  <= host_addr;
         bus.wdata <= host_wdata;
      end
   end

   //----------------------------------------------------------------------
   // Response stage, edge N+1
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         host_rvalid <= 1'b0;
      end else begin
         host_rvalid <= rd_pend;               // Single-cycle strobe
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pend) begin
         host_rdata <= bus.rdata;              // Hold last read data
      end
   end

endmodule

/* hw/fme_err_csr.sv */
// Register file with sticky error capture. Sources are levels, a held source
// wins over a W1C clear in the same cycle. Unmapped words read 0, writes dropped

`timescale 1ns/10ps

module fme_err_csr
   import fme_csr_pkg::*;
   import fme_msg_pkg::*;
#(
   parameter logic [DFH_NEXT_W-1:0] NEXT_DFH_OFFSET = 24'h010000
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   fme_regbus_if.slave          bus,
   input  logic [N_ERR_SRC-1:0] err_src,
   output logic                 err_summary
);

   logic [REG_DATA_W-1:0] dfh;
   logic [REG_DATA_W-1:0] scratch;
   err_vec_t              err_status;
   err_vec_t              err_mask;
   err_vec_t              err_first;
   logic [N_ERR_INJ-1:0]  err_inject;   // Bit 0 cat, 1 fat, 2 warn

   err_vec_t              err_set;      // Error levels this cycle
   err_vec_t              err_clr;      // W1C bits this cycle
   logic                  wr_en;

   assign wr_en = (bus.cmd == CMD_WRITE);

   //----------------------------------------------------------------------
   // Feature header, constant
   //----------------------------------------------------------------------
   always_comb begin
      dfh                                = '0;
      dfh[DFH_ID_W-1:0]                  = DFH_FEATURE_ID;
      dfh[DFH_NEXT_LSB +: DFH_NEXT_W]    = NEXT_DFH_OFFSET;
      dfh[DFH_EOL_BIT]                   = 1'b1;    // Last feature in list
   end

   //----------------------------------------------------------------------
   // Plain read/write registers
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch    <= '0;
         err_mask   <= ERR_MASK_RESET;
         err_inject <= '0;
      end else if (wr_en) begin
         case (bus.addr)
            ADDR_SCRATCH:    scratch    <= bus.wdata;
            ADDR_ERR_MASK:   err_mask   <= bus.wdata[N_ERR-1:0];
            ADDR_ERR_INJECT: err_inject <= bus.wdata[N_ERR_INJ-1:0];
            default: begin
               // DFH, status and first error handled elsewhere
            end
         endcase
      end
   end

   //----------------------------------------------------------------------
   // Error status and first-error capture
   //----------------------------------------------------------------------
   // Fabric levels in the low bits, injection as levels above them
   always_comb begin
      err_set                   = '0;
      err_set[N_ERR_SRC-1:0]    = err_src;
      err_set[ERR_BIT_CAT_INJ]  = err_inject[0];
      err_set[ERR_BIT_FAT_INJ]  = err_inject[1];
      err_set[ERR_BIT_WARN_INJ] = err_inject[2];
   end

   always_comb begin
      err_clr = '0;
      if (wr_en && bus.addr == ADDR_ERR_STATUS) begin
         err_clr = bus.wdata[N_ERR-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err_status <= '0;
         err_first  <= '0;
      end else begin
         // Set after clear, so a live source keeps its bit
         err_status <= (err_status & ~err_clr) | err_set;

         if (wr_en && bus.addr == ADDR_ERR_FIRST) begin
            err_first <= '0;
         end else if (err_status == '0 && err_set != '0) begin
            err_first <= err_set;              // Only from a clean status
         end
      end
   end

   // Unmasked summary, one edge behind the status
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err_summary <= 1'b0;
      end else begin
         err_summary <= |(err_status & ~err_mask);
      end
   end

   //----------------------------------------------------------------------
   // Read mux, same cycle as the command
   //----------------------------------------------------------------------
   always_comb begin
      bus.rdata = '0;
      case (bus.addr)
         ADDR_DFH:        bus.rdata                = dfh;
         ADDR_SCRATCH:    bus.rdata                = scratch;
         ADDR_ERR_STATUS: bus.rdata[N_ERR-1:0]     = err_status;
         ADDR_ERR_MASK:   bus.rdata[N_ERR-1:0]     = err_mask;
         ADDR_ERR_INJECT: bus.rdata[N_ERR_INJ-1:0] = err_inject;
         ADDR_ERR_FIRST:  bus.rdata[N_ERR-1:0]     = err_first;
         default:         bus.rdata                = '0;    // Unmapped
      endcase
   end

endmodule

/* hw/fme_irq_msg.sv */
// Interrupt message sender. One message per rising summary, edges that arrive
// while a message waits for msg_ready merge into it

`timescale 1ns/10ps

module fme_irq_msg
   import fme_msg_pkg::*;
#(
   parameter logic [MSG_ADDR_W-1:0] IRQ_MSG_ADDR = 20'h80010,
   parameter logic [MSG_DATA_W-1:0] IRQ_VECTOR   = 64'd6
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  err_summary,
   output logic                  msg_valid,
   output logic [MSG_ADDR_W-1:0] msg_addr,
   output logic [MSG_DATA_W-1:0] msg_data,
   input  logic                  msg_ready
);

   msg_state_t state;
   msg_state_t state_nxt;
   logic       summary_q;     // Previous summary
   logic       summary_rise;

   //----------------------------------------------------------------------
   // Rising edge of the error summary
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         summary_q <= 1'b0;
      end else begin
         summary_q <= err_summary;
      end
   end

   assign summary_rise = err_summary & ~summary_q;

   //----------------------------------------------------------------------
   // Sender FSM
   //----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         MSG_IDLE: begin
            if (summary_rise) begin
               state_nxt = MSG_SEND;
            end
         end
         MSG_SEND: begin
            if (msg_ready) begin
               state_nxt = MSG_IDLE;           // Transfer on this edge
            end
         end
         default: state_nxt = MSG_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= MSG_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Error to msg_valid is three edges: status, summary, FSM
   assign msg_valid = (state == MSG_SEND);

   // Fixed payload, stable for the whole handshake
   assign msg_addr  = IRQ_MSG_ADDR;
   assign msg_data  = IRQ_VECTOR;

endmodule

/* hw/fme_mgmt_top.sv */
// Management block top. Single clock, synchronous active-low reset
// Host bus has no ready, the message port obeys msg_ready

`timescale 1ns/10ps

module fme_mgmt_top
   import fme_csr_pkg::*;
   import fme_msg_pkg::*;
#(
   parameter logic [DFH_NEXT_W-1:0] NEXT_DFH_OFFSET = 24'h010000,
   parameter logic [MSG_ADDR_W-1:0] IRQ_MSG_ADDR    = 20'h80010,
   parameter logic [MSG_DATA_W-1:0] IRQ_VECTOR      = 64'd6
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Host register requests
   input  logic                  host_valid,
   input  logic                  host_write,
   input  logic [REG_ADDR_W-1:0] host_addr,
   input  logic [REG_DATA_W-1:0] host_wdata,
   output logic                  host_rvalid,
   output logic [REG_DATA_W-1:0] host_rdata,
   // Fabric error levels
   input  logic [N_ERR_SRC-1:0]  err_src,
   // Outbound interrupt message
   output logic                  msg_valid,
   output logic [MSG_ADDR_W-1:0] msg_addr,
   output logic [MSG_DATA_W-1:0] msg_data,
   input  logic                  msg_ready
);

   logic err_summary;    // Registered unmasked error level

   fme_regbus_if bus_if ();

   //----------------------------------------------------------------------
   // Register path
   //----------------------------------------------------------------------
   fme_mmio_front fme_mmio_front_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_valid  (host_valid),
      .host_write  (host_write),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .host_rvalid (host_rvalid),
      .host_rdata  (host_rdata),
      .bus         (bus_if)
   );

   fme_err_csr #(
      .NEXT_DFH_OFFSET (NEXT_DFH_OFFSET)
   ) fme_err_csr_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus         (bus_if),
      .err_src     (err_src),
      .err_summary (err_summary)
   );

   //----------------------------------------------------------------------
   // Interrupt message
   //----------------------------------------------------------------------
   fme_irq_msg #(
      .IRQ_MSG_ADDR (IRQ_MSG_ADDR),
      .IRQ_VECTOR   (IRQ_VECTOR)
   ) fme_irq_msg_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .err_summary (err_summary),
      .msg_valid   (msg_valid),
      .msg_addr    (msg_addr),
      .msg_data    (msg_data),
      .msg_ready   (msg_ready)
   );

endmodule

/* bench/fme_mgmt_properties.sv */
// Handshake and response timing checks, bound into fme_mgmt_top
// Sampled on the rising clock, quiet while rst_n is low

`timescale 1ns/10ps

module fme_mgmt_properties
   import fme_msg_pkg::*;
(
   input logic                  clk,
   input logic                  rst_n,
   input logic                  host_valid,
   input logic                  host_write,
   input logic                  host_rvalid,
   input logic                  msg_valid,
   input logic [MSG_ADDR_W-1:0] msg_addr,
   input logic [MSG_DATA_W-1:0] msg_data,
   input logic                  msg_ready
);

   int unsigned fail_cnt = 0;    // Failed assertions so far

   //----------------------------------------------------------------------
   // Outbound message
   //----------------------------------------------------------------------
   // Stalled message keeps valid and payload
   a_msg_stable: assert property (@(posedge clk) disable iff (!rst_n)
      msg_valid && !msg_ready |=> msg_valid && $stable(msg_addr) && $stable(msg_data))
      else begin
         fail_cnt++;
         $error("msg_valid or its fields changed before msg_ready");
      end

   //----------------------------------------------------------------------
   // Read response timing
   //----------------------------------------------------------------------
   a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
      host_valid && !host_write |-> ##2 host_rvalid)
      else begin
         fail_cnt++;
         $error("read request without host_rvalid two cycles later");
      end

   a_rd_origin: assert property (@(posedge clk) disable iff (!rst_n)
      host_rvalid |-> $past(host_valid && !host_write, 2))    // No stray responses
      else begin
         fail_cnt++;
         $error("host_rvalid without a read two cycles earlier");
      end

   // First cycle out of reset
   a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !msg_valid && !host_rvalid)
      else begin
         fail_cnt++;
         $error("msg_valid or host_rvalid high right after reset");
      end

endmodule

bind fme_mgmt_top fme_mgmt_properties fme_mgmt_properties_inst (
   .clk         (clk),
   .rst_n       (rst_n),
   .host_valid  (host_valid),
   .host_write  (host_write),
   .host_rvalid (host_rvalid),
   .msg_valid   (msg_valid),
   .msg_addr    (msg_addr),
   .msg_data    (msg_data),
   .msg_ready   (msg_ready)
);

/* bench/fme_mgmt_tb.sv */
// Directed testbench for the management block. Stops at the first mismatch
// Inputs change and outputs are sampled 1 ns after the rising edge

`timescale 1ns/10ps

module fme_mgmt_tb
   import fme_csr_pkg::*;
   import fme_msg_pkg::*;
();

   localparam logic [23:0]           TB_NEXT_DFH = 24'h00A5C3;
   localparam logic [MSG_ADDR_W-1:0] TB_MSG_ADDR = 20'h4B2A0;
   localparam logic [MSG_DATA_W-1:0] TB_VECTOR   = 64'h0000_0000_0000_0021;

   localparam int CLK_NS       = 4;
   localparam int RST_CYCLES   = 5;
   localparam int MSG_LATENCY  = 3;      // Error level to msg_valid
   localparam int MSG_WAIT_MAX = 20;
   localparam int MASK_WINDOW  = 20;     // Quiet cycles for a masked error

   // Cycle budget per test for the watchdog
   localparam int PLANNED_CYCLES = RST_CYCLES + 120 + 80 + 160 + 80 + 120 + 80;
   localparam int MARGIN_NS      = 200;

   logic                  clk;
   logic                  rst_n;
   logic                  host_valid;
   logic                  host_wr;
   logic [REG_ADDR_W-1:0] host_addr;
   logic [REG_DATA_W-1:0] host_wdata;
   logic                  host_rvalid;
   logic [REG_DATA_W-1:0] host_rdata;
   logic [N_ERR_SRC-1:0]  err_src;
   logic                  msg_valid;
   logic [MSG_ADDR_W-1:0] msg_addr;
   logic [MSG_DATA_W-1:0] msg_data;
   logic                  msg_ready;

   fme_mgmt_top #(
      .NEXT_DFH_OFFSET (TB_NEXT_DFH),
      .IRQ_MSG_ADDR    (TB_MSG_ADDR),
      .IRQ_VECTOR      (TB_VECTOR)
   ) fme_mgmt_top_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_valid  (host_valid),
      .host_write  (host_wr),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .host_rvalid (host_rvalid),
      .host_rdata  (host_rdata),
      .err_src     (err_src),
      .msg_valid   (msg_valid),
      .msg_addr    (msg_addr),
      .msg_data    (msg_data),
      .msg_ready   (msg_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   //----------------------------------------------------------------------
   // Failure reporting and typed compares
   //----------------------------------------------------------------------
   task automatic stop_failed();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic fail_run(input string what);
      $display("t=%0t %s", $time, what);
      stop_failed();
   endtask

   task automatic check_reg(input string name, input logic [REG_DATA_W-1:0] exp,
                            input logic [REG_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("error t=%0t %s expected %h actual %h", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_err(input string name, input err_vec_t exp, input err_vec_t act);
      if (act !== exp) begin
         $display("error t=%0t %s expected %b actual %b", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_msg(input logic [MSG_ADDR_W-1:0] exp_addr,
                            input logic [MSG_DATA_W-1:0] exp_data);
      if (msg_addr !== exp_addr) begin
         $display("error t=%0t msg_addr expected %h actual %h", $time, exp_addr, msg_addr);
         stop_failed();
      end
      if (msg_data !== exp_data) begin
         $display("error t=%0t msg_data expected %h actual %h", $time, exp_data, msg_data);
         stop_failed();
      end
   endtask

   //----------------------------------------------------------------------
   // Bus drivers and message sink end 1 ns after an edge
   //----------------------------------------------------------------------
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic host_write(input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_DATA_W-1:0] data);
      host_valid = 1'b1;
      host_wr    = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      idle(1);
      host_valid = 1'b0;
      host_wr    = 1'b0;
   endtask

   // Fixed two-cycle read latency
   task automatic host_read(input logic [REG_ADDR_W-1:0] addr,
                            output logic [REG_DATA_W-1:0] data);
      host_valid = 1'b1;
      host_wr    = 1'b0;
      host_addr  = addr;
      idle(1);
      host_valid = 1'b0;
      idle(1);
      if (host_rvalid !== 1'b1)
         fail_run($sformatf("no read response for address %0d", addr));
      else
         data = host_rdata;
   endtask

   task automatic read_check_reg(input logic [REG_ADDR_W-1:0] addr, input string name,
                                 input logic [REG_DATA_W-1:0] exp);
      logic [REG_DATA_W-1:0] data;
      host_read(addr, data);
      check_reg(name, exp, data);
   endtask

   task automatic read_check_err(input logic [REG_ADDR_W-1:0] addr, input string name,
                                 input err_vec_t exp);
      logic [REG_DATA_W-1:0] data;
      host_read(addr, data);
      check_err(name, exp, data[N_ERR-1:0]);
      check_reg({name, " upper bits"}, '0, data >> N_ERR);
   endtask

   task automatic pulse_src(input int i);
      err_src[i] = 1'b1;
      idle(1);
      err_src[i] = 1'b0;
   endtask

   // Sink with a random stall before msg_ready
   // lat counts the cycles up to msg_valid
   task automatic wait_msg(output int lat);
      int stall;
      lat = 0;
      while (msg_valid !== 1'b1 && lat < MSG_WAIT_MAX) begin
         idle(1);
         lat++;
      end
      if (msg_valid !== 1'b1) begin
         fail_run("no interrupt message arrived");
      end else begin
         stall = $urandom % 8;
         repeat (stall) begin
            check_msg(TB_MSG_ADDR, TB_VECTOR);
            idle(1);
            if (msg_valid !== 1'b1)
               fail_run("msg_valid dropped while msg_ready was low");
         end
         check_msg(TB_MSG_ADDR, TB_VECTOR);
         msg_ready = 1'b1;
         idle(1);                               // Transfer edge
         msg_ready = 1'b0;
      end
   endtask

   task automatic expect_no_msg(input int n);
      repeat (n) begin
         idle(1);
         if (msg_valid !== 1'b0)
            fail_run("unexpected interrupt message");
      end
   endtask

   //----------------------------------------------------------------------
   // Directed tests
   //----------------------------------------------------------------------
   task automatic test_reset_values();
      logic [REG_DATA_W-1:0] exp_dfh;
      exp_dfh        = '0;
      exp_dfh[11:0]  = DFH_FEATURE_ID;
      exp_dfh[39:16] = TB_NEXT_DFH;
      exp_dfh[40]    = 1'b1;                    // End of list
      read_check_reg(ADDR_DFH, "dfh", exp_dfh);
      for (int a = 1; a < 16; a++)
         read_check_reg(REG_ADDR_W'(a), $sformatf("reg %0d after reset", a), '0);
      for (int a = 6; a < 16; a++)
         host_write(REG_ADDR_W'(a), {$urandom, $urandom});
      host_write(ADDR_DFH, '1);                 // Read only
      read_check_reg(ADDR_DFH, "dfh", exp_dfh);
      for (int a = 1; a < 16; a++)
         read_check_reg(REG_ADDR_W'(a), $sformatf("reg %0d after writes", a), '0);
   endtask

   task automatic test_scratch();
      logic [REG_DATA_W-1:0] val;
      logic [REG_DATA_W-1:0] last;
      for (int i = 0; i < 8; i++) begin
         val = {$urandom, $urandom};
         host_write(ADDR_SCRATCH, val);
         read_check_reg(ADDR_SCRATCH, "scratch", val);   // Read right behind write
      end
      val  = {$urandom, $urandom};
      last = {$urandom, $urandom};
      host_write(ADDR_SCRATCH, val);
      host_write(ADDR_SCRATCH, last);          // Second write wins
      read_check_reg(ADDR_SCRATCH, "scratch", last);
      read_check_reg(ADDR_SCRATCH, "scratch", last);
   endtask

   task automatic test_err_sources();
      err_vec_t exp;
      host_write(ADDR_ERR_MASK, '1);            // No messages here
      for (int i = 0; i < N_ERR_SRC; i++) begin
         exp = err_vec_t'(1) << i;
         pulse_src(i);
         read_check_err(ADDR_ERR_STATUS, "err_status", exp);
         read_check_err(ADDR_ERR_FIRST, "err_first", exp);
         host_write(ADDR_ERR_STATUS, 64'(exp));
         host_write(ADDR_ERR_FIRST, '0);
         read_check_err(ADDR_ERR_STATUS, "err_status", '0);
         read_check_err(ADDR_ERR_FIRST, "err_first", '0);
      end
      // Later error leaves the first capture alone
      pulse_src(1);
      pulse_src(3);
      read_check_err(ADDR_ERR_STATUS, "err_status", 7'b000_1010);
      read_check_err(ADDR_ERR_FIRST, "err_first", 7'b000_0010);
      host_write(ADDR_ERR_STATUS, '1);
      read_check_err(ADDR_ERR_STATUS, "err_status", '0);
      read_check_err(ADDR_ERR_FIRST, "err_first", 7'b000_0010);
      host_write(ADDR_ERR_FIRST, '0);
      read_check_err(ADDR_ERR_FIRST, "err_first", '0);
      // Live source beats the clear
      err_src[0] = 1'b1;
      idle(1);
      host_write(ADDR_ERR_STATUS, '1);
      read_check_err(ADDR_ERR_STATUS, "err_status", 7'b000_0001);
      err_src[0] = 1'b0;
      host_write(ADDR_ERR_STATUS, '1);
      host_write(ADDR_ERR_FIRST, '0);
      read_check_err(ADDR_ERR_STATUS, "err_status", '0);
   endtask

   task automatic test_inject();
      int       inj_bit[3] = '{ERR_BIT_CAT_INJ, ERR_BIT_FAT_INJ, ERR_BIT_WARN_INJ};
      err_vec_t exp;
      for (int k = 0; k < 3; k++) begin
         exp = err_vec_t'(1) << inj_bit[k];
         host_write(ADDR_ERR_INJECT, 64'(1) << k);
         read_check_reg(ADDR_ERR_INJECT, "err_inject", 64'(1) << k);
         read_check_err(ADDR_ERR_STATUS, "err_status", exp);
         host_write(ADDR_ERR_INJECT, '0);
         host_write(ADDR_ERR_STATUS, '1);
         read_check_err(ADDR_ERR_STATUS, "err_status", '0);
      end
      host_write(ADDR_ERR_FIRST, '0);
      host_write(ADDR_ERR_MASK, '0);            // Unmask is quiet on a clean status
      read_check_err(ADDR_ERR_MASK, "err_mask", '0);
   endtask

   task automatic test_irq_msg();
      int lat;
      err_src[1] = 1'b1;
      wait_msg(lat);
      if (lat != MSG_LATENCY)
         fail_run($sformatf("first message after %0d cycles, not %0d", lat, MSG_LATENCY));
      expect_no_msg(10);                        // Held source gives no repeat
      err_src[1] = 1'b0;
      host_write(ADDR_ERR_STATUS, '1);
      read_check_err(ADDR_ERR_STATUS, "err_status", '0);
      idle(2);
      err_src[3] = 1'b1;
      wait_msg(lat);
      if (lat != MSG_LATENCY)
         fail_run($sformatf("second message after %0d cycles, not %0d", lat, MSG_LATENCY));
      expect_no_msg(10);
      err_src[3] = 1'b0;
      host_write(ADDR_ERR_STATUS, '1);
      host_write(ADDR_ERR_FIRST, '0);
      read_check_err(ADDR_ERR_STATUS, "err_status", '0);
      expect_no_msg(5);
   endtask

   task automatic test_masked();
      host_write(ADDR_ERR_MASK, 64'(1) << 2);
      pulse_src(2);
      expect_no_msg(MASK_WINDOW);
      read_check_err(ADDR_ERR_STATUS, "err_status", err_vec_t'(1) << 2);
      host_write(ADDR_ERR_STATUS, '1);
      host_write(ADDR_ERR_FIRST, '0);
      host_write(ADDR_ERR_MASK, '0);
      expect_no_msg(5);
   endtask

   //----------------------------------------------------------------------
   // Watchdog and main sequence
   //----------------------------------------------------------------------
   initial begin
      #(PLANNED_CYCLES * CLK_NS + MARGIN_NS);
      fail_run("watchdog timeout, the tests did not finish");
   end

   initial begin
      void'($urandom(32'h3537));
      rst_n      = 1'b0;
      host_valid = 1'b0;
      host_wr    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      err_src    = '0;
      msg_ready  = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      test_reset_values();
      test_scratch();
      test_err_sources();
      test_inject();
      test_irq_msg();
      test_masked();

      if (fme_mgmt_top_inst.fme_mgmt_properties_inst.fail_cnt != 0) begin
         fail_run("assertion failures in the bound property checker");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

/* fme_mgmt_top.f */
hw/fme_csr_pkg.sv
hw/fme_msg_pkg.sv
hw/fme_regbus_if.sv
hw/fme_mmio_front.sv
hw/fme_err_csr.sv
hw/fme_irq_msg.sv
hw/fme_mgmt_top.sv
bench/fme_mgmt_properties.sv
bench/fme_mgmt_tb.sv
